/* logic/byte_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_skid_buffer (
    input  wire                     clk,
    input  wire                     rst,

    // input side
    input  wire  byte_stream_pkg::byte_t in_tdata,
    input  wire                     in_tvalid,
    input  wire                     in_tlast,
    input  wire                     in_tuser,

    // ready back to the source
    output logic                    ready_early,
    output logic                    ready_reg,

    // output side
    output byte_stream_pkg::byte_t  out_tdata,
    output logic                    out_tvalid,
    output logic                    out_tlast,
    output logic                    out_tuser,
    input  wire                     out_tready
);

    import byte_stream_pkg::*;

    // spare slot for the byte that arrives after a stall
    byte_t temp_tdata;
    logic  temp_tvalid;
    logic  temp_tlast;
    logic  temp_tuser;

    logic  out_tvalid_next;
    logic  temp_tvalid_next;

    logic  load_out_from_in;
    logic  load_temp_from_in;
    logic  load_out_from_temp;

    // room next cycle unless the spare slot would fill up
    assign ready_early = out_tready || (!temp_tvalid && (!out_tvalid || !in_tvalid));

    always_comb begin
        out_tvalid_next = out_tvalid;
        temp_tvalid_next = temp_tvalid;

        load_out_from_in = 1'b0;
        load_temp_from_in = 1'b0;
        load_out_from_temp = 1'b0;

        if (ready_reg) begin
            if (out_tready || !out_tvalid) begin
                // straight through when the output is free
                out_tvalid_next = in_tvalid;
                load_out_from_in = 1'b1;
            end else begin
                // park in the spare slot while the output is stalled
                temp_tvalid_next = in_tvalid;
                load_temp_from_in = 1'b1;
            end
        end else if (out_tready) begin
            out_tvalid_next = temp_tvalid;
            temp_tvalid_next = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_tvalid <= 1'b0;
            temp_tvalid <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            out_tvalid <= out_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
            ready_reg <= ready_early;
        end

        if (load_out_from_in) begin
            out_tdata <= in_tdata;
            out_tlast <= in_tlast;
            out_tuser <= in_tuser;
        end else if (load_out_from_temp) begin
            out_tdata <= temp_tdata;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end

        if (load_temp_from_in) begin
            temp_tdata <= in_tdata;
            temp_tlast <= in_tlast;
            temp_tuser <= in_tuser;
        end
    end

endmodule

`default_nettype wire

/* logic/byte_stream_pkg.sv */
`default_nettype none

package byte_stream_pkg;

    // payload and output streams are one byte wide
    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;

endpackage

`default_nettype wire

/* logic/net_hdr_pkg.sv */
`default_nettype none

package net_hdr_pkg;

    // udp header is always eight bytes on the wire
    localparam int UDP_HDR_BYTES = 8;
    // ip header without options
    localparam int IP_HDR_BYTES = 20;

    localparam int PORT_W = 16;
    localparam int IP_ADDR_W = 32;
    localparam int TTL_W = 8;

    typedef struct packed {
        logic [PORT_W-1:0] source_port;
        logic [PORT_W-1:0] dest_port;
        logic [PORT_W-1:0] length;
        logic [PORT_W-1:0] checksum;
    } udp_hdr_fields_t;

    // bytes[UDP_HDR_BYTES-1] is the first byte on the wire
    typedef union packed {
        udp_hdr_fields_t fields;
        logic [UDP_HDR_BYTES-1:0][7:0] bytes;
    } udp_hdr_t;

endpackage

`default_nettype wire

/* logic/udp_ip_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx (
    input  wire                                 clk,
    input  wire                                 rst,

    // udp header input
    input  wire                                 s_hdr_valid,
    output wire                                 s_hdr_ready,
    input  wire  [net_hdr_pkg::IP_ADDR_W-1:0]   s_ip_source_ip,
    input  wire  [net_hdr_pkg::IP_ADDR_W-1:0]   s_ip_dest_ip,
    input  wire  [net_hdr_pkg::TTL_W-1:0]       s_ip_ttl,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_source_port,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_dest_port,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_length,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_checksum,

    // payload input
    input  wire  byte_stream_pkg::byte_t        s_payload_tdata,
    input  wire                                 s_payload_tvalid,
    output wire                                 s_payload_tready,
    input  wire                                 s_payload_tlast,
    input  wire                                 s_payload_tuser,

    // ip header output
    output wire                                 m_ip_hdr_valid,
    input  wire                                 m_ip_hdr_ready,
    output wire  [net_hdr_pkg::IP_ADDR_W-1:0]   m_ip_source_ip,
    output wire  [net_hdr_pkg::IP_ADDR_W-1:0]   m_ip_dest_ip,
    output wire  [net_hdr_pkg::TTL_W-1:0]       m_ip_ttl,
    output wire  [net_hdr_pkg::PORT_W-1:0]      m_ip_length,

    // udp header bytes followed by payload
    output wire  byte_stream_pkg::byte_t        m_payload_tdata,
    output wire                                 m_payload_tvalid,
    input  wire                                 m_payload_tready,
    output wire                                 m_payload_tlast,
    output wire                                 m_payload_tuser,

    // status
    output wire                                 busy,
    output wire                                 error_payload_early_termination
);

    import byte_stream_pkg::*;

    byte_t int_tdata;
    wire   int_tvalid;
    wire   int_tlast;
    wire   int_tuser;
    wire   ready_early;
    wire   ready_reg;

    udp_tx_ctrl udp_tx_ctrl_inst (
        .clk                             (clk),
        .rst                             (rst),
        .s_hdr_valid                     (s_hdr_valid),
        .s_hdr_ready                     (s_hdr_ready),
        .s_ip_source_ip                  (s_ip_source_ip),
        .s_ip_dest_ip                    (s_ip_dest_ip),
        .s_ip_ttl                        (s_ip_ttl),
        .s_udp_source_port               (s_udp_source_port),
        .s_udp_dest_port                 (s_udp_dest_port),
        .s_udp_length                    (s_udp_length),
        .s_udp_checksum                  (s_udp_checksum),
        .m_ip_hdr_valid                  (m_ip_hdr_valid),
        .m_ip_hdr_ready                  (m_ip_hdr_ready),
        .m_ip_source_ip                  (m_ip_source_ip),
        .m_ip_dest_ip                    (m_ip_dest_ip),
        .m_ip_ttl                        (m_ip_ttl),
        .m_ip_length                     (m_ip_length),
        .s_payload_tdata                 (s_payload_tdata),
        .s_payload_tvalid                (s_payload_tvalid),
        .s_payload_tready                (s_payload_tready),
        .s_payload_tlast                 (s_payload_tlast),
        .s_payload_tuser                 (s_payload_tuser),
        .int_tdata                       (int_tdata),
        .int_tvalid                      (int_tvalid),
        .int_tlast                       (int_tlast),
        .int_tuser                       (int_tuser),
        .ready_early                     (ready_early),
        .ready_reg                       (ready_reg),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    // absorbs back-pressure from the output stream
    byte_skid_buffer byte_skid_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .in_tdata    (int_tdata),
        .in_tvalid   (int_tvalid),
        .in_tlast    (int_tlast),
        .in_tuser    (int_tuser),
        .ready_early (ready_early),
        .ready_reg   (ready_reg),
        .out_tdata   (m_payload_tdata),
        .out_tvalid  (m_payload_tvalid),
        .out_tlast   (m_payload_tlast),
        .out_tuser   (m_payload_tuser),
        .out_tready  (m_payload_tready)
    );

endmodule

`default_nettype wire

/* logic/udp_tx_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_tx_ctrl (
    input  wire                                 clk,
    input  wire                                 rst,

    // header input
    input  wire                                 s_hdr_valid,
    output logic                                s_hdr_ready,
    input  wire  [net_hdr_pkg::IP_ADDR_W-1:0]   s_ip_source_ip,
    input  wire  [net_hdr_pkg::IP_ADDR_W-1:0]   s_ip_dest_ip,
    input  wire  [net_hdr_pkg::TTL_W-1:0]       s_ip_ttl,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_source_port,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_dest_port,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_length,
    input  wire  [net_hdr_pkg::PORT_W-1:0]      s_udp_checksum,

    // ip header output
    output logic                                m_ip_hdr_valid,
    input  wire                                 m_ip_hdr_ready,
    output logic [net_hdr_pkg::IP_ADDR_W-1:0]   m_ip_source_ip,
    output logic [net_hdr_pkg::IP_ADDR_W-1:0]   m_ip_dest_ip,
    output logic [net_hdr_pkg::TTL_W-1:0]       m_ip_ttl,
    output logic [net_hdr_pkg::PORT_W-1:0]      m_ip_length,

    // payload input
    input  wire  byte_stream_pkg::byte_t        s_payload_tdata,
    input  wire                                 s_payload_tvalid,
    output logic                                s_payload_tready,
    input  wire                                 s_payload_tlast,
    input  wire                                 s_payload_tuser,

    // internal stream towards the output buffer
    output byte_stream_pkg::byte_t              int_tdata,
    output logic                                int_tvalid,
    output logic                                int_tlast,
    output logic                                int_tuser,
    input  wire                                 ready_early,
    input  wire                                 ready_reg,

    // status
    output logic                                busy,
    output logic                                error_payload_early_termination
);

    import net_hdr_pkg::*;
    import byte_stream_pkg::*;

    localparam logic [1:0] ST_IDLE         = 2'd0;
    localparam logic [1:0] ST_HEADER       = 2'd1;
    localparam logic [1:0] ST_PAYLOAD      = 2'd2;
    localparam logic [1:0] ST_PAYLOAD_LAST = 2'd3;

    localparam int PTR_W = $clog2(UDP_HDR_BYTES);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(UDP_HDR_BYTES - 1);

    logic [1:0]        state_reg;
    logic [1:0]        state_next;

    logic              store_hdr;
    logic              store_last;

    logic [PTR_W-1:0]  hdr_ptr_reg;
    logic [PTR_W-1:0]  hdr_ptr_next;
    logic [PORT_W-1:0] count_reg;
    logic [PORT_W-1:0] count_next;

    udp_hdr_t          hdr_reg;
    byte_t             last_byte_reg;

    logic              s_hdr_ready_next;
    logic              s_payload_tready_next;
    logic              m_ip_hdr_valid_next;
    logic              error_next;

    always_comb begin
        state_next = state_reg;

        s_hdr_ready_next = 1'b0;
        s_payload_tready_next = 1'b0;
        m_ip_hdr_valid_next = m_ip_hdr_valid && !m_ip_hdr_ready;
        error_next = 1'b0;

        store_hdr = 1'b0;
        store_last = 1'b0;

        hdr_ptr_next = hdr_ptr_reg;
        count_next = count_reg;

        int_tdata = '0;
        int_tvalid = 1'b0;
        int_tlast = 1'b0;
        int_tuser = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                hdr_ptr_next = '0;
                // hold off a new header while the previous ip header is pending
                s_hdr_ready_next = !m_ip_hdr_valid_next;

                if (s_hdr_valid && s_hdr_ready) begin
                    store_hdr = 1'b1;
                    s_hdr_ready_next = 1'b0;
                    m_ip_hdr_valid_next = 1'b1;
                    // payload bytes still owed after the udp header
                    count_next = s_udp_length - PORT_W'(UDP_HDR_BYTES);
                    state_next = ST_HEADER;
                end
            end

            ST_HEADER: begin
                int_tdata = hdr_reg.bytes[UDP_HDR_BYTES - 1 - int'(hdr_ptr_reg)];

                if (ready_reg) begin
                    int_tvalid = 1'b1;
                    hdr_ptr_next = hdr_ptr_reg + 1'b1;
                    if (hdr_ptr_reg == LAST_PTR) begin
                        // open the payload input for the next cycle
                        s_payload_tready_next = ready_early;
                        state_next = ST_PAYLOAD;
                    end
                end
            end

            ST_PAYLOAD: begin
                s_payload_tready_next = ready_early;

                int_tdata = s_payload_tdata;
                int_tlast = s_payload_tlast;
                int_tuser = s_payload_tuser;

                if (s_payload_tvalid && s_payload_tready) begin
                    int_tvalid = 1'b1;
                    count_next = count_reg - 1'b1;

                    if (s_payload_tlast) begin
                        if (count_reg != PORT_W'(1)) begin
                            // frame ended before the udp length ran out
                            int_tuser = 1'b1;
                            error_next = 1'b1;
                        end
                        s_hdr_ready_next = !m_ip_hdr_valid_next;
                        s_payload_tready_next = 1'b0;
                        state_next = ST_IDLE;
                    end else if (count_reg == PORT_W'(1)) begin
                        // keep this byte for the tlast beat once the length is used up
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = ST_PAYLOAD_LAST;
                    end
                end
            end

            ST_PAYLOAD_LAST: begin
                // drain the rest of the input frame
                s_payload_tready_next = ready_early;

                int_tdata = last_byte_reg;
                int_tlast = s_payload_tlast;
                int_tuser = s_payload_tuser;

                if (s_payload_tvalid && s_payload_tready && s_payload_tlast) begin
                    int_tvalid = 1'b1;
                    s_hdr_ready_next = !m_ip_hdr_valid_next;
                    s_payload_tready_next = 1'b0;
                    state_next = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_IDLE;
            hdr_ptr_reg <= '0;
            s_hdr_ready <= 1'b0;
            s_payload_tready <= 1'b0;
            m_ip_hdr_valid <= 1'b0;
            busy <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state_reg <= state_next;
            hdr_ptr_reg <= hdr_ptr_next;
            s_hdr_ready <= s_hdr_ready_next;
            s_payload_tready <= s_payload_tready_next;
            m_ip_hdr_valid <= m_ip_hdr_valid_next;
            busy <= state_next != ST_IDLE;
            error_payload_early_termination <= error_next;
        end

        count_reg <= count_next;

        if (store_hdr) begin
            hdr_reg.fields.source_port <= s_udp_source_port;
            hdr_reg.fields.dest_port <= s_udp_dest_port;
            hdr_reg.fields.length <= s_udp_length;
            hdr_reg.fields.checksum <= s_udp_checksum;

            m_ip_source_ip <= s_ip_source_ip;
            m_ip_dest_ip <= s_ip_dest_ip;
            m_ip_ttl <= s_ip_ttl;
            m_ip_length <= s_udp_length + PORT_W'(IP_HDR_BYTES);
        end

        if (store_last) begin
            last_byte_reg <= s_payload_tdata;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
logic/net_hdr_pkg.sv
logic/byte_stream_pkg.sv
logic/udp_tx_ctrl.sv
logic/byte_skid_buffer.sv
logic/udp_ip_tx.sv
verification/udp_ip_tx_assert.sv
verification/udp_ip_tx_tb.sv

/* verification/udp_ip_tx_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx_assert (
    input wire                         clk,
    input wire                         rst,
    input wire byte_stream_pkg::byte_t m_payload_tdata,
    input wire                         m_payload_tvalid,
    input wire                         m_payload_tready,
    input wire                         m_payload_tlast,
    input wire                         s_hdr_ready,
    input wire                         m_ip_hdr_valid,
    input wire                         error_payload_early_termination
);

    int failures = 0;

    // stalled output beat holds its data
    stable_while_stalled: assert property (@(posedge clk) disable iff (rst)
        m_payload_tvalid && !m_payload_tready |=>
            m_payload_tvalid && $stable(m_payload_tdata) && $stable(m_payload_tlast))
    else begin
        failures++;
        $error("output beat changed or dropped while stalled");
    end

    // no new header while the ip header is pending
    no_hdr_ready_while_pending: assert property (@(posedge clk) disable iff (rst)
        !(s_hdr_ready && m_ip_hdr_valid))
    else begin
        failures++;
        $error("s_hdr_ready high with m_ip_hdr_valid pending");
    end

    single_cycle_error: assert property (@(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination)
    else begin
        failures++;
        $error("early termination error high two cycles in a row");
    end

endmodule

`default_nettype wire

/* verification/udp_ip_tx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_ip_tx_tb;

    import net_hdr_pkg::*;
    import byte_stream_pkg::*;

    localparam int TIMEOUT = 2000;
    localparam logic [31:0] LCG_SEED = 32'h925e_511c;

    logic clk = 1'b0;
    logic rst;
    logic s_hdr_valid, s_hdr_ready, m_ip_hdr_valid, m_ip_hdr_ready;
    logic [IP_ADDR_W-1:0] s_ip_source_ip, s_ip_dest_ip, m_ip_source_ip, m_ip_dest_ip;
    logic [TTL_W-1:0] s_ip_ttl, m_ip_ttl;
    logic [PORT_W-1:0] s_udp_source_port, s_udp_dest_port, s_udp_length, s_udp_checksum;
    logic [PORT_W-1:0] m_ip_length;
    byte_t s_payload_tdata, m_payload_tdata;
    logic s_payload_tvalid, s_payload_tready, s_payload_tlast, s_payload_tuser;
    logic m_payload_tvalid, m_payload_tready, m_payload_tlast, m_payload_tuser;
    logic busy, error_payload_early_termination;

    // separate generators for data, input gaps and output stalls
    logic [31:0] data_rng = LCG_SEED;
    logic [31:0] gap_rng = LCG_SEED;
    logic [31:0] ready_rng = LCG_SEED;
    logic stress;
    logic frame_out_done;
    int error_pulses;
    byte_t payload_q[$], exp_data[$], got_data[$];
    logic got_last[$], got_user[$];

    always #4 clk = ~clk;

    udp_ip_tx udp_ip_tx_inst (.*);

    bind udp_ip_tx udp_ip_tx_assert assert_inst (.*);

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic stop_on_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at %0t", $time);
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %02h, expected %02h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_addr(input string name, input logic [IP_ADDR_W-1:0] got,
                                input logic [IP_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %08h, expected %08h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_len(input string name, input logic [PORT_W-1:0] got,
                               input logic [PORT_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_timeout(input int waited, input string what);
        if (waited > TIMEOUT) begin
            $display("Timeout at %0t: no %s after %0d cycles", $time, what, waited);
            stop_on_failure();
        end
    endtask

    task automatic send_header(input logic [IP_ADDR_W-1:0] src_ip, dst_ip,
                               input logic [TTL_W-1:0] ttl,
                               input logic [PORT_W-1:0] sport, dport, len, csum);
        int waited;
        waited = 0;
        s_hdr_valid <= 1'b1;
        s_ip_source_ip <= src_ip;
        s_ip_dest_ip <= dst_ip;
        s_ip_ttl <= ttl;
        s_udp_source_port <= sport;
        s_udp_dest_port <= dport;
        s_udp_length <= len;
        s_udp_checksum <= csum;
        do begin
            @(posedge clk);
            waited++;
            check_timeout(waited, "header handshake");
        end while (!s_hdr_ready);
        s_hdr_valid <= 1'b0;
    endtask

    task automatic send_payload(input int n);
        int waited;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            r = lcg_next(gap_rng);
            if (stress && r[31]) begin
                s_payload_tvalid <= 1'b0;
                @(posedge clk);
            end
            s_payload_tvalid <= 1'b1;
            s_payload_tdata <= payload_q[i];
            s_payload_tlast <= (i == n - 1);
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                check_timeout(waited, "payload handshake");
            end while (!s_payload_tready);
            compare_bit("busy", busy, 1'b1);
            compare_bit("s_hdr_ready", s_hdr_ready, 1'b0);
        end
        s_payload_tvalid <= 1'b0;
        s_payload_tlast <= 1'b0;
    endtask

    // gathers output beats up to tlast and stalls the output at random under stress
    task automatic collect_frame();
        int waited;
        logic [31:0] r;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done) begin
            r = lcg_next(ready_rng);
            m_payload_tready <= stress ? r[29] : 1'b1;
            @(posedge clk);
            waited++;
            check_timeout(waited, "output tlast");
            if (error_payload_early_termination) begin
                error_pulses++;
            end
            if (m_payload_tvalid && m_payload_tready) begin
                got_data.push_back(m_payload_tdata);
                got_last.push_back(m_payload_tlast);
                got_user.push_back(m_payload_tuser);
                done = m_payload_tlast;
            end
        end
        m_payload_tready <= 1'b1;
        frame_out_done = 1'b1;
    endtask

    task automatic check_ip_hdr(input logic hold, input logic [IP_ADDR_W-1:0] src_ip, dst_ip,
                                input logic [TTL_W-1:0] ttl, input logic [PORT_W-1:0] ip_len);
        int waited;
        waited = 0;
        if (hold) begin
            m_ip_hdr_ready <= 1'b0;
            // header of this frame taken before s_hdr_ready must stay low
            do begin
                @(posedge clk);
                waited++;
                check_timeout(waited, "ip header valid while held");
            end while (!m_ip_hdr_valid);
            while (!frame_out_done) begin
                @(posedge clk);
                waited++;
                check_timeout(waited, "end of frame while ip header held");
                compare_bit("s_hdr_ready", s_hdr_ready, 1'b0);
            end
            // frame is done but the ip header is still pending
            repeat (4) begin
                @(posedge clk);
                compare_bit("m_ip_hdr_valid", m_ip_hdr_valid, 1'b1);
                compare_bit("s_hdr_ready", s_hdr_ready, 1'b0);
            end
            m_ip_hdr_ready <= 1'b1;
        end
        do begin
            @(posedge clk);
            waited++;
            check_timeout(waited, "ip header handshake");
        end while (!(m_ip_hdr_valid && m_ip_hdr_ready));
        compare_addr("m_ip_source_ip", m_ip_source_ip, src_ip);
        compare_addr("m_ip_dest_ip", m_ip_dest_ip, dst_ip);
        compare_byte("m_ip_ttl", m_ip_ttl, ttl);
        compare_len("m_ip_length", m_ip_length, ip_len);
    endtask

    task automatic run_frame(input logic hold, input logic [PORT_W-1:0] udp_len, input int n_in);
        logic [31:0] r;
        logic [IP_ADDR_W-1:0] src_ip, dst_ip;
        logic [TTL_W-1:0] ttl;
        logic [PORT_W-1:0] sport, dport, csum;
        int n_body;
        logic early;
        src_ip = lcg_next(data_rng);
        dst_ip = lcg_next(data_rng);
        r = lcg_next(data_rng);
        ttl = r[31:24];
        sport = r[15:0];
        r = lcg_next(data_rng);
        dport = r[31:16];
        csum = r[15:0];
        payload_q.delete();
        for (int i = 0; i < n_in; i++) begin
            r = lcg_next(data_rng);
            payload_q.push_back(r[23:16]);
        end
        n_body = udp_len - 16'd8;
        early = n_in < n_body;
        // udp header goes out most significant byte first
        exp_data = '{sport[15:8], sport[7:0], dport[15:8], dport[7:0],
                     udp_len[15:8], udp_len[7:0], csum[15:8], csum[7:0]};
        for (int i = 0; i < n_in && i < n_body; i++) begin
            exp_data.push_back(payload_q[i]);
        end
        got_data.delete();
        got_last.delete();
        got_user.delete();
        error_pulses = 0;
        frame_out_done = 1'b0;
        fork
            begin
                send_header(src_ip, dst_ip, ttl, sport, dport, udp_len, csum);
                send_payload(n_in);
            end
            collect_frame();
            check_ip_hdr(hold, src_ip, dst_ip, ttl, udp_len + 16'd20);
        join
        compare_len("output byte count", PORT_W'(got_data.size()), PORT_W'(exp_data.size()));
        for (int i = 0; i < got_data.size(); i++) begin
            compare_byte("m_payload_tdata", got_data[i], exp_data[i]);
            compare_bit("m_payload_tlast", got_last[i], i == got_data.size() - 1);
            compare_bit("m_payload_tuser", got_user[i], early && (i == got_data.size() - 1));
        end
        compare_len("error pulse count", PORT_W'(error_pulses), early ? 16'd1 : 16'd0);
    endtask

    task automatic basic_frame_test();
        stress = 1'b0;
        run_frame(1'b0, 16'd8 + 16'd12, 12);
    endtask

    task automatic back_pressure_test();
        stress = 1'b1;
        run_frame(1'b0, 16'd8 + 16'd25, 25);
        run_frame(1'b0, 16'd8 + 16'd3, 3);
    endtask

    task automatic truncation_test();
        stress = 1'b1;
        run_frame(1'b0, 16'd8 + 16'd6, 15);
        stress = 1'b0;
        run_frame(1'b0, 16'd8 + 16'd1, 4);
    endtask

    task automatic early_termination_test();
        stress = 1'b0;
        run_frame(1'b0, 16'd8 + 16'd20, 7);
        stress = 1'b1;
        run_frame(1'b0, 16'd8 + 16'd9, 1);
    endtask

    task automatic back_to_back_test();
        stress = 1'b1;
        run_frame(1'b1, 16'd8 + 16'd10, 10);
        run_frame(1'b0, 16'd8 + 16'd5, 5);
    endtask

    initial begin
        rst <= 1'b1;
        s_hdr_valid <= 1'b0;
        s_ip_source_ip <= '0;
        s_ip_dest_ip <= '0;
        s_ip_ttl <= '0;
        s_udp_source_port <= '0;
        s_udp_dest_port <= '0;
        s_udp_length <= '0;
        s_udp_checksum <= '0;
        m_ip_hdr_ready <= 1'b1;
        s_payload_tdata <= '0;
        s_payload_tvalid <= 1'b0;
        s_payload_tlast <= 1'b0;
        s_payload_tuser <= 1'b0;
        m_payload_tready <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare_bit("s_hdr_ready", s_hdr_ready, 1'b0);
        compare_bit("s_payload_tready", s_payload_tready, 1'b0);
        compare_bit("m_ip_hdr_valid", m_ip_hdr_valid, 1'b0);
        compare_bit("m_payload_tvalid", m_payload_tvalid, 1'b0);
        compare_bit("busy", busy, 1'b0);
        compare_bit("error_payload_early_termination", error_payload_early_termination, 1'b0);
        basic_frame_test();
        back_pressure_test();
        truncation_test();
        early_termination_test();
        back_to_back_test();
        if (udp_ip_tx_inst.assert_inst.failures != 0) begin
            $display("%0d concurrent assertion failures", udp_ip_tx_inst.assert_inst.failures);
            stop_on_failure();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
